// ==== vlog.f ====
rtl/gpif_frame_pkg.sv
rtl/credit_ingress_fifo.sv
rtl/frame_splitter.sv
rtl/credit_egress_port.sv
rtl/gpif_framer_top.sv
dv/gpif_framer_props.sv
dv/gpif_framer_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = gpif_framer_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/gpif_framer_tb.sv ====
// Testbench for the GPIF framer with credited source, credited sink and frame model
`timescale 1ns/100ps

module gpif_framer_tb
   import gpif_frame_pkg::*;
();

   localparam int FRAME_LEN      = 16;
   localparam int FIFO_DEPTH     = 8;
   localparam int EGRESS_CREDITS = 4;
   localparam int SEED           = 99931;
   localparam int STALL_LEN      = 60;
   localparam int NUM_PKTS       = 4;

   // Header length in 32-bit words and lines sent up to the eof
   localparam int PKT_WORDS [NUM_PKTS] = '{4, 8, 20, 20};
   localparam int PKT_LINES [NUM_PKTS] = '{7, 16, 33, 40};
   localparam int FPP_VALS  [2]        = '{1, 3};

   logic       clk;
   logic       reset_i;
   logic [7:0] frames_per_packet_i;
   line_t      in_line_i;
   logic       in_valid_i;
   logic       credit_o;
   line_t      out_line_o;
   logic       out_valid_o;
   logic       credit_i = 1'b0;
   logic       stall_on = 1'b0;

   line_t  exp_q [$];
   line_t  exp_line;
   integer src_seed = SEED;
   integer sink_seed = SEED;
   int     fpp_cur;
   int     src_sent = 0;
   int     src_back;
   int     sink_rx;
   int     sink_back;
   int     owed;
   int     held;
   int     stall_age;
   int     total_lines;
   int     cycle_limit;
   int     cycles = 0;
   int     err_out = 0;
   int     err_stall = 0;
   int     err_end = 0;
   bit     timed_out = 1'b0;

   gpif_framer_top #(
      .FRAME_LEN      (FRAME_LEN),
      .FIFO_DEPTH     (FIFO_DEPTH),
      .EGRESS_CREDITS (EGRESS_CREDITS)
   ) gpif_framer_top_i (
      .clk                 (clk),
      .reset_i             (reset_i),
      .frames_per_packet_i (frames_per_packet_i),
      .in_line_i           (in_line_i),
      .in_valid_i          (in_valid_i),
      .credit_o            (credit_o),
      .out_line_o          (out_line_o),
      .out_valid_o         (out_valid_o),
      .credit_i            (credit_i)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic int frames_for(input int n_lines);
      return (n_lines + FRAME_LEN - 1) / FRAME_LEN;
   endfunction

   task automatic finish_run();
      int prop_fails;
      prop_fails = gpif_framer_top_i.gpif_framer_props_i.fail_cnt;
      $display("Errors: output %0d, stall %0d, end %0d, properties %0d, lines %0d of %0d",
               err_out, err_stall, err_end, prop_fails, sink_rx, total_lines);
      if (err_out + err_stall + err_end + prop_fails == 0 && !timed_out)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   endtask

   // Source sends only while it holds an upstream credit
   task automatic drive_line(input line_t ln);
      bit done;
      done = 1'b0;
      while (!done)
      begin
         @(posedge clk);
         if ((FIFO_DEPTH + src_back - src_sent) > 0 && ($random(src_seed) % 4) != 0)
         begin
            in_line_i  <= ln;
            in_valid_i <= 1'b1;
            src_sent++;
            done = 1'b1;
         end
         else
            in_valid_i <= 1'b0;
      end
   endtask

   // Predicts the framed output and then sends the packet
   task automatic send_packet(input int words, input int n_lines);
      line_t pkt [$];
      line_t ln;
      int    n_end;
      int    frames;
      n_end = (2 * words < n_lines) ? 2 * words : n_lines;
      frames = frames_for(n_end);
      for (int i = 0; i < n_lines; i++)
      begin
         ln.occ  = 1'b0;
         ln.sof  = (i == 0);
         ln.eof  = (i == n_lines - 1);
         ln.data = (i == 0) ? 16'(words) : 16'($random(src_seed));
         pkt.push_back(ln);
      end
      for (int i = 0; i < frames * FRAME_LEN; i++)
      begin
         ln.sof  = (i % FRAME_LEN == 0);
         ln.eof  = (i % FRAME_LEN == FRAME_LEN - 1);
         ln.data = (i < n_end) ? pkt[i].data : '0;
         ln.occ  = ln.eof && (i == frames * FRAME_LEN - 1) && (frames != fpp_cur);
         exp_q.push_back(ln);
      end
      foreach (pkt[i])
         drive_line(pkt[i]);
   endtask

   always @(posedge clk)
   begin
      if (reset_i)
         src_back <= 0;
      else if (credit_o)
         src_back <= src_back + 1;
   end

   // Sink returns credits after random delays and none while stalled
   always @(posedge clk)
   begin
      if (reset_i)
      begin
         sink_rx   = 0;
         sink_back = 0;
         owed      = 0;
         stall_age = 0;
         credit_i <= 1'b0;
      end
      else
      begin
         held = EGRESS_CREDITS + sink_back - sink_rx;
         stall_age = stall_on ? stall_age + 1 : 0;
         assert (!(stall_age > 2 && held == 0 && out_valid_o))
         else
         begin
            $display("Error at %0t ns: output sent during stall with no credit", $time);
            err_stall++;
         end
         if (credit_i)
            sink_back++;
         if (out_valid_o)
         begin
            sink_rx++;
            owed++;
         end
         if (owed > 0 && !stall_on && ($random(sink_seed) & 3) != 0)
         begin
            credit_i <= 1'b1;
            owed--;
         end
         else
            credit_i <= 1'b0;
      end
   end

   always @(posedge clk)
   begin
      if (!reset_i && out_valid_o)
      begin
         assert (exp_q.size() != 0)
         else
         begin
            $display("Error at %0t ns: unexpected output line %h", $time, out_line_o);
            err_out++;
         end
         if (exp_q.size() != 0)
         begin
            exp_line = exp_q.pop_front();
            assert (out_line_o.sof == exp_line.sof && out_line_o.eof == exp_line.eof)
            else
            begin
               $display("Error at %0t ns: sof/eof %b%b, expected %b%b", $time,
                        out_line_o.sof, out_line_o.eof, exp_line.sof, exp_line.eof);
               err_out++;
            end
            assert (out_line_o.data == exp_line.data)
            else
            begin
               $display("Error at %0t ns: data %h, expected %h", $time,
                        out_line_o.data, exp_line.data);
               err_out++;
            end
            assert (out_line_o.occ == exp_line.occ)
            else
            begin
               $display("Error at %0t ns: occ %b, expected %b", $time,
                        out_line_o.occ, exp_line.occ);
               err_out++;
            end
         end
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= cycle_limit)
      begin
         $display("Timeout after %0d cycles with %0d lines still expected", cycles, exp_q.size());
         timed_out = 1'b1;
         finish_run();
      end
   end

   // One long stretch without downstream credits
   initial
   begin
      while (sink_rx < 40)
         @(negedge clk);
      @(posedge clk);
      stall_on <= 1'b1;
      repeat (STALL_LEN) @(posedge clk);
      stall_on <= 1'b0;
   end

   initial
   begin
      reset_i             = 1'b1;
      in_valid_i          = 1'b0;
      in_line_i           = '0;
      frames_per_packet_i = 8'd1;
      total_lines = 0;
      for (int p = 0; p < NUM_PKTS; p++)
         total_lines += 2 * frames_for(PKT_LINES[p]) * FRAME_LEN;
      cycle_limit = total_lines * 4 + STALL_LEN + 200;
      repeat (5) @(posedge clk);
      reset_i <= 1'b0;
      for (int r = 0; r < 2; r++)
      begin
         fpp_cur = FPP_VALS[r];
         @(posedge clk);
         frames_per_packet_i <= 8'(fpp_cur);
         for (int p = 0; p < NUM_PKTS; p++)
            send_packet(PKT_WORDS[p], PKT_LINES[p]);
         @(posedge clk);
         in_valid_i <= 1'b0;
         while (exp_q.size() != 0)
            @(negedge clk);
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      assert (src_back == src_sent)
      else
      begin
         $display("Error at %0t ns: %0d upstream credits for %0d lines", $time,
                  src_back, src_sent);
         err_end++;
      end
      assert (sink_rx == total_lines)
      else
      begin
         $display("Error at %0t ns: %0d lines received, expected %0d", $time,
                  sink_rx, total_lines);
         err_end++;
      end
      finish_run();
   end

endmodule

// ==== dv/gpif_framer_props.sv ====
// Bound checks on the framer credit links and on its reset state
`timescale 1ns/100ps

module gpif_framer_props
   import gpif_frame_pkg::*;
#(
   parameter int FIFO_DEPTH     = 8,
   parameter int EGRESS_CREDITS = 4
)
(
   input logic                            clk,
   input logic                            reset_i,
   input logic                            in_valid_i,
   input logic                            credit_o,
   input logic                            out_valid_o,
   input logic                            credit_i,
   input logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count_i,
   input split_state_e                    split_state_i
);

   int lines_in;
   int credits_up;
   int lines_out;
   int credits_down;
   int fail_cnt = 0;

   // Totals up to the previous edge
   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         lines_in     <= 0;
         credits_up   <= 0;
         lines_out    <= 0;
         credits_down <= 0;
      end
      else
      begin
         lines_in     <= lines_in + int'(in_valid_i);
         credits_up   <= credits_up + int'(credit_o);
         lines_out    <= lines_out + int'(out_valid_o);
         credits_down <= credits_down + int'(credit_i);
      end
   end

   assert property (@(posedge clk) reset_i |=> !out_valid_o && !credit_o)
   else
   begin
      $error("Outputs active after a reset cycle");
      fail_cnt++;
   end

   assert property (@(posedge clk) reset_i |=> split_state_i == SPLIT_IDLE && fifo_count_i == '0)
   else
   begin
      $error("Splitter busy or buffer not empty after reset");
      fail_cnt++;
   end

   // Downstream sends bounded by initial credits plus returns
   assert property (@(posedge clk) disable iff (reset_i)
                    (lines_out + int'(out_valid_o)) <= (EGRESS_CREDITS + credits_down))
   else
   begin
      $error("Line sent downstream without a credit");
      fail_cnt++;
   end

   assert property (@(posedge clk) disable iff (reset_i)
                    credit_o |-> credits_up < lines_in)
   else
   begin
      $error("Upstream credit returned for a line never received");
      fail_cnt++;
   end

   assert property (@(posedge clk) disable iff (reset_i)
                    in_valid_i |-> int'(fifo_count_i) < FIFO_DEPTH)
   else
   begin
      $error("Line pushed into a full input buffer");
      fail_cnt++;
   end

endmodule

bind gpif_framer_top gpif_framer_props #(
   .FIFO_DEPTH     (FIFO_DEPTH),
   .EGRESS_CREDITS (EGRESS_CREDITS)
) gpif_framer_props_i (
   .clk           (clk),
   .reset_i       (reset_i),
   .in_valid_i    (in_valid_i),
   .credit_o      (credit_o),
   .out_valid_o   (out_valid_o),
   .credit_i      (credit_i),
   .fifo_count_i  (credit_ingress_fifo_i.count),
   .split_state_i (frame_splitter_i.state)
);

// ==== rtl/gpif_framer_top.sv ====
// GPIF stream framer: credited input buffer, frame splitter, credited output
`timescale 1ns/100ps

module gpif_framer_top
   import gpif_frame_pkg::*;
#(
   parameter int FRAME_LEN      = 256,
   parameter int FIFO_DEPTH     = 8,
   parameter int EGRESS_CREDITS = 4
)
(
   input  logic       clk,
   input  logic       reset_i,
   input  logic [7:0] frames_per_packet_i,
   input  line_t      in_line_i,
   input  logic       in_valid_i,
   output logic       credit_o,
   output line_t      out_line_o,
   output logic       out_valid_o,
   input  logic       credit_i
);

   line_t buf_line;
   logic  buf_valid;
   logic  buf_ready;
   line_t split_line;
   logic  split_valid;
   logic  split_ready;

   credit_ingress_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) credit_ingress_fifo_i (
      .clk         (clk),
      .reset_i     (reset_i),
      .in_line_i   (in_line_i),
      .in_valid_i  (in_valid_i),
      .buf_line_o  (buf_line),
      .buf_valid_o (buf_valid),
      .buf_ready_i (buf_ready),
      .credit_o    (credit_o)
   );

   frame_splitter #(
      .FRAME_LEN (FRAME_LEN)
   ) frame_splitter_i (
      .clk                 (clk),
      .reset_i             (reset_i),
      .frames_per_packet_i (frames_per_packet_i),
      .buf_line_i          (buf_line),
      .buf_valid_i         (buf_valid),
      .buf_ready_o         (buf_ready),
      .split_line_o        (split_line),
      .split_valid_o       (split_valid),
      .split_ready_i       (split_ready)
   );

   credit_egress_port #(
      .EGRESS_CREDITS (EGRESS_CREDITS)
   ) credit_egress_port_i (
      .clk           (clk),
      .reset_i       (reset_i),
      .split_line_i  (split_line),
      .split_valid_i (split_valid),
      .split_ready_o (split_ready),
      .out_line_o    (out_line_o),
      .out_valid_o   (out_valid_o),
      .credit_i      (credit_i)
   );

endmodule

// ==== rtl/credit_egress_port.sv ====
// Registered output stage, spends one downstream credit per line sent
`timescale 1ns/100ps

module credit_egress_port
   import gpif_frame_pkg::*;
#(
   parameter int EGRESS_CREDITS = 4
)
(
   input  logic  clk,
   input  logic  reset_i,
   input  line_t split_line_i,
   input  logic  split_valid_i,
   output logic  split_ready_o,
   output line_t out_line_o,
   output logic  out_valid_o,
   input  logic  credit_i
);

   localparam int CNT_W = $clog2(EGRESS_CREDITS + 1);

   logic [CNT_W-1:0] credit_cnt;
   logic             send;

   // Output register holds a line for one cycle only, so it is
   // always empty or draining and the credit count alone gates it
   assign split_ready_o = (credit_cnt != '0);
   assign send          = split_valid_i & split_ready_o;

   always_ff @(posedge clk)
   begin
      if (send)
         out_line_o <= split_line_i;
   end

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         credit_cnt  <= CNT_W'(EGRESS_CREDITS);
         out_valid_o <= 1'b0;
      end
      else
      begin
         // Credit is taken at accept, returns may land the same cycle
         credit_cnt  <= credit_cnt - CNT_W'(send) + CNT_W'(credit_i);
         out_valid_o <= send;
      end
   end

endmodule

// ==== rtl/frame_splitter.sv ====
// Splits VITA packets into fixed GPIF frames and zero pads the last one
`timescale 1ns/100ps

module frame_splitter
   import gpif_frame_pkg::*;
#(
   parameter int FRAME_LEN = 256
)
(
   input  logic       clk,
   input  logic       reset_i,
   input  logic [7:0] frames_per_packet_i,
   input  line_t      buf_line_i,
   input  logic       buf_valid_i,
   output logic       buf_ready_o,
   output line_t      split_line_o,
   output logic       split_valid_o,
   input  logic       split_ready_i
);

   localparam logic [LEN_W-1:0] FRAME_LEN_L = LEN_W'(FRAME_LEN);

   split_state_e     state;
   logic [LEN_W-1:0] length;
   logic [LEN_W-1:0] frame_left;
   logic [7:0]       frame_cnt;
   logic             xfer;
   logic             in_eof;
   logic             pkt_last;
   logic             frame_last;
   logic             next_idle;
   logic             eof_out;
   logic             sof_out;
   logic             occ_out;

   // Input is ignored while padding
   assign buf_ready_o   = split_ready_i & (state != SPLIT_PAD);
   assign split_valid_o = buf_valid_i | (state == SPLIT_PAD);
   assign xfer          = buf_valid_i & buf_ready_o;

   // Counters run down to 2, header line is taken before they load
   assign in_eof     = buf_line_i.eof;
   assign pkt_last   = (length == LEN_W'(2)) | in_eof;
   assign frame_last = (frame_left == LEN_W'(2));

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         state      <= SPLIT_IDLE;
         length     <= '0;
         frame_left <= '0;
         frame_cnt  <= '0;
      end
      else
      begin
         case (state)
            SPLIT_IDLE:
               if (xfer)
               begin
                  // Header length is in 32-bit words
                  length     <= {buf_line_i.data[14:0], 1'b0};
                  frame_left <= FRAME_LEN_L;
                  frame_cnt  <= 8'd1;
                  state      <= in_eof ? SPLIT_PAD : SPLIT_FRAME;
               end
            SPLIT_FRAME:
               if (xfer)
               begin
                  if (frame_last && pkt_last)
                     state <= SPLIT_IDLE;
                  else if (frame_last)
                  begin
                     length    <= length - 1'b1;
                     frame_cnt <= frame_cnt + 1'b1;
                     state     <= SPLIT_NEW_FRAME;
                  end
                  else if (pkt_last)
                  begin
                     frame_left <= frame_left - 1'b1;
                     state      <= SPLIT_PAD;
                  end
                  else
                  begin
                     frame_left <= frame_left - 1'b1;
                     length     <= length - 1'b1;
                  end
               end
            SPLIT_NEW_FRAME:
               if (xfer)
               begin
                  frame_left <= FRAME_LEN_L;
                  if (pkt_last)
                     state <= SPLIT_PAD;
                  else
                  begin
                     length <= length - 1'b1;
                     state  <= SPLIT_FRAME;
                  end
               end
            SPLIT_PAD:
               if (split_ready_i)
               begin
                  if (frame_last)
                     state <= SPLIT_IDLE;
                  else
                     frame_left <= frame_left - 1'b1;
               end
            default:
               state <= SPLIT_IDLE;
         endcase
      end
   end

   // Last line of the packet's last frame
   assign next_idle = split_ready_i & frame_last &
                      ((state == SPLIT_PAD) |
                       ((state == SPLIT_FRAME) & buf_valid_i & pkt_last));

   assign eof_out = frame_last & ((state == SPLIT_FRAME) | (state == SPLIT_PAD));
   assign sof_out = (state == SPLIT_IDLE) | (state == SPLIT_NEW_FRAME);
   assign occ_out = eof_out & next_idle & (frames_per_packet_i != frame_cnt);

   always_comb
   begin
      split_line_o.occ  = occ_out;
      split_line_o.eof  = eof_out;
      split_line_o.sof  = sof_out;
      split_line_o.data = (state == SPLIT_PAD) ? '0 : buf_line_i.data;
   end

endmodule

// ==== rtl/credit_ingress_fifo.sv ====
// Credited input buffer, returns one upstream credit per line popped
`timescale 1ns/100ps

module credit_ingress_fifo
   import gpif_frame_pkg::*;
#(
   parameter int FIFO_DEPTH = 8
)
(
   input  logic  clk,
   input  logic  reset_i,
   input  line_t in_line_i,
   input  logic  in_valid_i,
   output line_t buf_line_o,
   output logic  buf_valid_o,
   input  logic  buf_ready_i,
   output logic  credit_o
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   line_t            mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   // Wraps at FIFO_DEPTH, depth need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(FIFO_DEPTH - 1))
         return '0;
      else
         return ptr + 1'b1;
   endfunction

   // Upstream only sends with a credit, so a push always has room
   assign push = in_valid_i;
   assign pop  = buf_valid_o & buf_ready_i;

   // Head comes from registered pointer and count
   assign buf_valid_o = (count != '0);
   assign buf_line_o  = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= in_line_i;
   end

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         credit_o <= 1'b0;
      end
      else
      begin
         if (push)
            wr_ptr <= ptr_inc(wr_ptr);
         if (pop)
            rd_ptr <= ptr_inc(rd_ptr);
         count <= count + CNT_W'(push) - CNT_W'(pop);
         // One credit back per freed entry
         credit_o <= pop;
      end
   end

endmodule

// ==== rtl/gpif_frame_pkg.sv ====
// GPIF framer shared types: line layout, splitter states and widths

package gpif_frame_pkg;

   // Host bus data width
   localparam int LINE_W = 16;

   // Width of the splitter line counters
   localparam int LEN_W = 16;

   // One 19-bit line, flags above the data word
   typedef struct packed
   {
      logic              occ;
      logic              eof;
      logic              sof;
      logic [LINE_W-1:0] data;
   } line_t;

   // Splitter FSM
   typedef enum logic [1:0]
   {
      // Waiting for a header line
      SPLIT_IDLE      = 2'd0,
      // Inside a frame, passing input lines
      SPLIT_FRAME     = 2'd1,
      // First line of a follow-on frame
      SPLIT_NEW_FRAME = 2'd2,
      // Zero fill up to the frame boundary
      SPLIT_PAD       = 2'd3
   } split_state_e;

endpackage
